//--- verif/key_expand_input.txt
# name clear en ack op len round key_i expected_key_o
# op 0 fwd 1 inv, len 0 AES-128 1 AES-256, keys are FIPS-197 byte streams with word 0 first
a128f_clr 1 0 0 0 0 0 2b7e151628aed2a6abf7158809cf4f3c00000000000000000000000000000000 0000000000000000000000000000000000000000000000000000000000000000
a128f_hold 0 1 0 0 0 1 2b7e151628aed2a6abf7158809cf4f3c00000000000000000000000000000000 a0fafe1788542cb123a339392a6c76052b7e151628aed2a6abf7158809cf4f3c
a128f_r01 0 1 1 0 0 1 2b7e151628aed2a6abf7158809cf4f3c00000000000000000000000000000000 a0fafe1788542cb123a339392a6c76052b7e151628aed2a6abf7158809cf4f3c
a128f_r02 0 1 1 0 0 2 a0fafe1788542cb123a339392a6c76052b7e151628aed2a6abf7158809cf4f3c f2c295f27a96b9435935807a7359f67fa0fafe1788542cb123a339392a6c7605
a128f_r03 0 1 1 0 0 3 f2c295f27a96b9435935807a7359f67fa0fafe1788542cb123a339392a6c7605 3d80477d4716fe3e1e237e446d7a883bf2c295f27a96b9435935807a7359f67f
a128f_r04 0 1 1 0 0 4 3d80477d4716fe3e1e237e446d7a883bf2c295f27a96b9435935807a7359f67f ef44a541a8525b7fb671253bdb0bad003d80477d4716fe3e1e237e446d7a883b
a128f_r05 0 1 1 0 0 5 ef44a541a8525b7fb671253bdb0bad003d80477d4716fe3e1e237e446d7a883b d4d1c6f87c839d87caf2b8bc11f915bcef44a541a8525b7fb671253bdb0bad00
a128f_r06 0 1 1 0 0 6 d4d1c6f87c839d87caf2b8bc11f915bcef44a541a8525b7fb671253bdb0bad00 6d88a37a110b3efddbf98641ca0093fdd4d1c6f87c839d87caf2b8bc11f915bc
a128f_r07 0 1 1 0 0 7 6d88a37a110b3efddbf98641ca0093fdd4d1c6f87c839d87caf2b8bc11f915bc 4e54f70e5f5fc9f384a64fb24ea6dc4f6d88a37a110b3efddbf98641ca0093fd
a128f_r08 0 1 1 0 0 8 4e54f70e5f5fc9f384a64fb24ea6dc4f6d88a37a110b3efddbf98641ca0093fd ead27321b58dbad2312bf5607f8d292f4e54f70e5f5fc9f384a64fb24ea6dc4f
a128f_r09 0 1 1 0 0 9 ead27321b58dbad2312bf5607f8d292f4e54f70e5f5fc9f384a64fb24ea6dc4f ac7766f319fadc2128d12941575c006eead27321b58dbad2312bf5607f8d292f
a128f_r10 0 1 1 0 0 10 ac7766f319fadc2128d12941575c006eead27321b58dbad2312bf5607f8d292f d014f9a8c9ee2589e13f0cc8b6630ca6ac7766f319fadc2128d12941575c006e
a128i_clr 1 0 0 1 0 10 d014f9a8c9ee2589e13f0cc8b6630ca6ac7766f319fadc2128d12941575c006e 0000000000000000000000000000000000000000000000000000000000000000
a128i_r10 0 1 1 1 0 10 d014f9a8c9ee2589e13f0cc8b6630ca6ac7766f319fadc2128d12941575c006e ac7766f319fadc2128d12941575c006ed014f9a8c9ee2589e13f0cc8b6630ca6
a128i_r09 0 1 1 1 0 9 ac7766f319fadc2128d12941575c006ed014f9a8c9ee2589e13f0cc8b6630ca6 ead27321b58dbad2312bf5607f8d292fac7766f319fadc2128d12941575c006e
a128i_r08 0 1 1 1 0 8 ead27321b58dbad2312bf5607f8d292fac7766f319fadc2128d12941575c006e 4e54f70e5f5fc9f384a64fb24ea6dc4fead27321b58dbad2312bf5607f8d292f
a256f_clr 1 0 0 0 1 0 603deb1015ca71be2b73aef0857d77811f352c073b6108d72d9810a30914dff4 0000000000000000000000000000000000000000000000000000000000000000
a256f_r00 0 1 1 0 1 0 603deb1015ca71be2b73aef0857d77811f352c073b6108d72d9810a30914dff4 1f352c073b6108d72d9810a30914dff4603deb1015ca71be2b73aef0857d7781
a256f_r01 0 1 1 0 1 1 603deb1015ca71be2b73aef0857d77811f352c073b6108d72d9810a30914dff4 1f352c073b6108d72d9810a30914dff49ba354118e6925afa51a8b5f2067fcde
a256f_r02 0 1 1 0 1 2 1f352c073b6108d72d9810a30914dff49ba354118e6925afa51a8b5f2067fcde 9ba354118e6925afa51a8b5f2067fcdea8b09c1a93d194cdbe49846eb75d5b9a
a256f_r03 0 1 1 0 1 3 9ba354118e6925afa51a8b5f2067fcdea8b09c1a93d194cdbe49846eb75d5b9a a8b09c1a93d194cdbe49846eb75d5b9ad59aecb85bf3c917fee94248de8ebe96
a256f_r04 0 1 1 0 1 4 a8b09c1a93d194cdbe49846eb75d5b9ad59aecb85bf3c917fee94248de8ebe96 d59aecb85bf3c917fee94248de8ebe96b5a9328a2678a647983122292f6c79b3
a256i_r05 0 1 1 1 1 5 b5a9328a2678a647983122292f6c79b3812c81addadf48ba24360af2fab8b464 d59aecb85bf3c917fee94248de8ebe96b5a9328a2678a647983122292f6c79b3
a256i_r04 0 1 1 1 1 4 d59aecb85bf3c917fee94248de8ebe96b5a9328a2678a647983122292f6c79b3 a8b09c1a93d194cdbe49846eb75d5b9ad59aecb85bf3c917fee94248de8ebe96
a256i_r03 0 1 1 1 1 3 a8b09c1a93d194cdbe49846eb75d5b9ad59aecb85bf3c917fee94248de8ebe96 9ba354118e6925afa51a8b5f2067fcdea8b09c1a93d194cdbe49846eb75d5b9a
a256i_r02 0 1 1 1 1 2 9ba354118e6925afa51a8b5f2067fcdea8b09c1a93d194cdbe49846eb75d5b9a 1f352c073b6108d72d9810a30914dff49ba354118e6925afa51a8b5f2067fcde
a256i_r01 0 1 1 1 1 1 1f352c073b6108d72d9810a30914dff49ba354118e6925afa51a8b5f2067fcde 603deb1015ca71be2b73aef0857d77811f352c073b6108d72d9810a30914dff4

//--- verilog.f
+incdir+hdl
hdl/aes_key_pkg.sv
hdl/aes_sbox.sv
hdl/aes_rcon_gen.sv
hdl/aes_sub_word.sv
hdl/aes_key_mix.sv
hdl/aes_key_expand.sv
verif/aes_key_expand_chk.sv
verif/aes_key_expand_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the key expansion testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps \
  --top-module aes_key_expand_tb -f verilog.f -o sim_aes_key_expand

./obj_dir/sim_aes_key_expand 2>&1 | tee sim.log

if grep -q "Simulation passed" sim.log; then
  echo "Run result: PASS"
else
  echo "Run result: FAIL"
  exit 1
fi

//--- verif/aes_key_expand_tb.sv
/*
  Testbench for the AES key expansion unit, one vector line per clock cycle.
  Key windows in the vector file are FIPS-197 byte streams, word 0 first.
  key_o is only compared on lines with en high.
*/
`include "aes_key_params.svh"

module aes_key_expand_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import aes_key_pkg::*;

  logic                    clk_i;
  logic                    rst_ni;
  logic                    en_i;
  logic                    out_ack_i;
  logic                    clear_i;
  ciph_op_e                op_i;
  key_len_e                key_len_i;
  logic [`AES_ROUND_W-1:0] round_i;
  key_win_t                key_i;
  key_win_t                key_o;
  logic                    out_req_o;

  // Vectors, one entry per file line
  string                   vec_name[$];
  logic                    vec_clr[$];
  logic                    vec_en[$];
  logic                    vec_ack[$];
  ciph_op_e                vec_op[$];
  key_len_e                vec_len[$];
  logic [`AES_ROUND_W-1:0] vec_round[$];
  key_win_t                vec_key[$];
  key_win_t                vec_exp[$];

  int checks;
  int errors;
  int cycles;
  int cycle_limit;
  bit load_ok;

  aes_key_expand aes_key_expand_i (.*);

  bind aes_key_expand aes_key_expand_chk u_chk (
    .clk_i     ( clk_i     ),
    .rst_ni    ( rst_ni    ),
    .en_i      ( en_i      ),
    .out_ack_i ( out_ack_i ),
    .clear_i   ( clear_i   ),
    .op_i      ( op_i      ),
    .key_len_i ( key_len_i ),
    .out_req_o ( out_req_o ),
    .rcon_i    ( rcon      )
  );

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // File byte 0 is the first FIPS byte of word 0 and lands in bits 7:0
  function automatic key_win_t stream_to_window(input logic [255:0] s);
    logic [255:0] flat;
    for (int b = 0; b < 32; b++) begin
      flat[8*b +: 8] = s[255-8*b -: 8];
    end
    return flat;
  endfunction

  task automatic load_vectors(output bit ok);
    int          fd;
    int          n;
    int          clr, en, ack, op, len, rnd;
    string       line;
    string       name;
    logic [255:0] key_s, exp_s;
    bit          bad;
    bad = 0;
    fd  = $fopen("verif/key_expand_input.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the vector file verif/key_expand_input.txt");
      bad = 1;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        // Skip comments and blank lines
        if (line.len() > 4 && line.getc(0) != "#") begin
          n = $sscanf(line, "%s %d %d %d %d %d %d %h %h",
                      name, clr, en, ack, op, len, rnd, key_s, exp_s);
          if (n != 9) begin
            $display("Malformed line in the vector file: %s", line);
            bad = 1;
          end else begin
            vec_name.push_back(name);
            vec_clr.push_back(clr[0]);
            vec_en.push_back(en[0]);
            vec_ack.push_back(ack[0]);
            vec_op.push_back(op[0] ? CIPH_INV : CIPH_FWD);
            vec_len.push_back(len[0] ? AES_256 : AES_128);
            vec_round.push_back(rnd[`AES_ROUND_W-1:0]);
            vec_key.push_back(stream_to_window(key_s));
            vec_exp.push_back(stream_to_window(exp_s));
          end
        end
      end
      $fclose(fd);
    end
    ok = !bad && (vec_name.size() > 0);
  endtask

  task automatic check_key(input string name, input key_win_t exp_key, input key_win_t act_key);
    checks++;
    if (act_key !== exp_key) begin
      errors++;
      $display("CHECK FAILED %s key_o expected %h actual %h", name, exp_key, act_key);
    end
  endtask

  task automatic check_req(input string name, input logic exp_req, input logic act_req);
    checks++;
    if (act_req !== exp_req) begin
      errors++;
      $display("CHECK FAILED %s out_req_o expected %b actual %b", name, exp_req, act_req);
    end
  endtask

  ////////////////////////////////////////
  // Clock and timeout
  ////////////////////////////////////////

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  initial begin
    cycles = 0;
    wait (cycle_limit > 0);
    while (cycles < cycle_limit) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout after %0d cycles, the vector run did not finish", cycles);
    $display("Simulation failed");
    $finish;
  end

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    rst_ni      = 1'b0;
    en_i        = 1'b0;
    out_ack_i   = 1'b0;
    clear_i     = 1'b0;
    op_i        = CIPH_FWD;
    key_len_i   = AES_128;
    round_i     = '0;
    key_i       = '0;
    checks      = 0;
    errors      = 0;
    cycle_limit = 0;
    load_vectors(load_ok);
    if (!load_ok) begin
      $display("No usable vectors, nothing was tested");
      $display("Simulation failed");
    end else begin
      // Vectors plus reset plus margin
      cycle_limit = vec_name.size() + 3 + 20;
      repeat (3) @(posedge clk_i);
      rst_ni <= 1'b1;
      for (int i = 0; i < vec_name.size(); i++) begin
        @(posedge clk_i);
        clear_i   <= vec_clr[i];
        en_i      <= vec_en[i];
        out_ack_i <= vec_ack[i];
        op_i      <= vec_op[i];
        key_len_i <= vec_len[i];
        round_i   <= vec_round[i];
        key_i     <= vec_key[i];
        // Outputs are settled mid cycle
        @(negedge clk_i);
        check_req(vec_name[i], vec_en[i], out_req_o);
        if (vec_en[i]) begin
          check_key(vec_name[i], vec_exp[i], key_o);
        end
      end
      @(posedge clk_i);
      en_i      <= 1'b0;
      out_ack_i <= 1'b0;
      clear_i   <= 1'b0;
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
        $display("Simulation passed");
      end else begin
        $display("Simulation failed");
      end
    end
    $finish;
  end

endmodule

//--- verif/aes_key_expand_chk.sv
/*
  Assertions bound to the key expansion top level.
  rcon_i is the Rcon register inside the top level.
*/
`include "aes_key_params.svh"

module aes_key_expand_chk (
  input logic                   clk_i,
  input logic                   rst_ni,
  input logic                   en_i,
  input logic                   out_ack_i,
  input logic                   clear_i,
  input aes_key_pkg::ciph_op_e  op_i,
  input aes_key_pkg::key_len_e  key_len_i,
  input logic                   out_req_o,
  input logic [`AES_RCON_W-1:0] rcon_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // Request is a copy of enable, no latency
  req_follows_en: assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_req_o == en_i)
    else $error("out_req_o differs from en_i");

  // Mode inputs must be driven
  mode_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown({op_i, key_len_i}))
    else $error("op_i or key_len_i is unknown");

  // No accepted round, no Rcon step
  rcon_holds: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (!out_ack_i && !clear_i) |=> $stable(rcon_i))
    else $error("Rcon changed without ack or clear");

endmodule

//--- hdl/aes_key_expand.sv
/*
  AES-128/256 key expansion, one round key window per pass.
  key_o and out_req_o are combinational, only the Rcon register holds state.
  A clear must precede each new schedule so that Rcon starts at the right value.
*/
`include "aes_key_params.svh"

module aes_key_expand (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    en_i,
  input  logic                    out_ack_i,
  input  logic                    clear_i,
  input  aes_key_pkg::ciph_op_e   op_i,
  input  aes_key_pkg::key_len_e   key_len_i,
  input  logic [`AES_ROUND_W-1:0] round_i,
  input  aes_key_pkg::key_win_t   key_i,
  output aes_key_pkg::key_win_t   key_o,
  output logic                    out_req_o
);

  import aes_key_pkg::*;

  logic [`AES_RCON_W-1:0] rcon;
  logic                   use_rcon;
  logic                   advance;
  key_word_t              irregular;

  // S-Box path has no latency, so the result is ready whenever enabled
  assign out_req_o = en_i;

  // Round accepted by the consumer
  assign advance = en_i & out_req_o & out_ack_i;

  ////////////////////////////////////////
  // Round constant
  ////////////////////////////////////////

  aes_rcon_gen u_aes_rcon_gen (
    .clk_i      ( clk_i     ),
    .rst_ni     ( rst_ni    ),
    .clear_i    ( clear_i   ),
    .advance_i  ( advance   ),
    .op_i       ( op_i      ),
    .key_len_i  ( key_len_i ),
    .round_i    ( round_i   ),
    .rcon_o     ( rcon      ),
    .use_rcon_o ( use_rcon  )
  );

  ////////////////////////////////////////
  // RotWord, SubWord and Rcon addition
  ////////////////////////////////////////

  aes_sub_word u_aes_sub_word (
    .key_i       ( key_i     ),
    .op_i        ( op_i      ),
    .key_len_i   ( key_len_i ),
    .round_i     ( round_i   ),
    .rcon_i      ( rcon      ),
    .use_rcon_i  ( use_rcon  ),
    .irregular_o ( irregular )
  );

  ////////////////////////////////////////
  // Word mixing
  ////////////////////////////////////////

  aes_key_mix u_aes_key_mix (
    .key_i       ( key_i     ),
    .irregular_i ( irregular ),
    .op_i        ( op_i      ),
    .key_len_i   ( key_len_i ),
    .round_i     ( round_i   ),
    .key_o       ( key_o     )
  );

endmodule

//--- hdl/aes_key_mix.sv
/*
  Regular part of the key schedule, XOR chains and word shifts.
  AES-128 uses words 3:0, the upper words carry the old lower half.
  AES-256 round 0 only swaps the halves, no new words are generated.
*/
`include "aes_key_params.svh"

module aes_key_mix (
  input  aes_key_pkg::key_win_t   key_i,
  input  aes_key_pkg::key_word_t  irregular_i,
  input  aes_key_pkg::ciph_op_e   op_i,
  input  aes_key_pkg::key_len_e   key_len_i,
  input  logic [`AES_ROUND_W-1:0] round_i,
  output aes_key_pkg::key_win_t   key_o
);

  import aes_key_pkg::*;

  key_win_t next;

  always_comb begin
    unique case (key_len_i)

      ////////////////////////////////////////
      // AES-128
      ////////////////////////////////////////
      AES_128: begin
        // Upper words unused, keep the old round key there
        next[7:4] = key_i[3:0];
        next[0]   = irregular_i ^ key_i[0];
        unique case (op_i)
          CIPH_FWD: begin
            // Chain upward from the new word 0
            for (int i = 1; i < 4; i++) begin
              next[i] = next[i-1] ^ key_i[i];
            end
          end
          CIPH_INV: begin
            // Adjacent forward words give back the older ones
            for (int i = 1; i < 4; i++) begin
              next[i] = key_i[i-1] ^ key_i[i];
            end
          end
        endcase
      end

      ////////////////////////////////////////
      // AES-256
      ////////////////////////////////////////
      AES_256: begin
        if (round_i == '0) begin
          // First pass only exchanges halves
          next = {key_i[3:0], key_i[7:4]};
        end else begin
          unique case (op_i)
            CIPH_FWD: begin
              // Old upper half moves down
              next[3:0] = key_i[7:4];
              next[4]   = irregular_i ^ key_i[0];
              for (int i = 1; i < 4; i++) begin
                next[i+4] = next[i+3] ^ key_i[i];
              end
            end
            CIPH_INV: begin
              // Old lower half moves up
              next[7:4] = key_i[3:0];
              next[0]   = irregular_i ^ key_i[4];
              for (int i = 0; i < 3; i++) begin
                next[i+1] = key_i[i+4] ^ key_i[i+5];
              end
            end
          endcase
        end
      end
    endcase
  end

  assign key_o = next;

endmodule

//--- hdl/aes_sub_word.sv
/*
  Irregular word of the key schedule: RotWord, SubWord and Rcon.
  Purely combinational, four byte S-Boxes in parallel.
*/
`include "aes_key_params.svh"

module aes_sub_word (
  input  aes_key_pkg::key_win_t   key_i,
  input  aes_key_pkg::ciph_op_e   op_i,
  input  aes_key_pkg::key_len_e   key_len_i,
  input  logic [`AES_ROUND_W-1:0] round_i,
  input  logic [`AES_RCON_W-1:0]  rcon_i,
  input  logic                    use_rcon_i,
  output aes_key_pkg::key_word_t  irregular_o
);

  import aes_key_pkg::*;

  key_word_t rot_in;
  key_word_t rot_out;
  key_word_t sub_in;
  key_word_t sub_out;
  logic      use_rot;

  // Pick the word that feeds RotWord
  always_comb begin
    unique case (key_len_i)
      AES_128: begin
        // Inverse order rebuilds the forward word 3 from two inputs
        rot_in = (op_i == CIPH_FWD) ? key_i[3] : key_i[3] ^ key_i[2];
      end
      AES_256: begin
        rot_in = (op_i == CIPH_FWD) ? key_i[7] : key_i[3];
      end
    endcase
  end

  // RotWord, first byte moves to the end
  assign rot_out = {rot_in[7:0], rot_in[31:8]};

  // AES-256 even rounds skip the rotation
  assign use_rot = !(key_len_i == AES_256 && !round_i[0]);
  assign sub_in  = use_rot ? rot_out : rot_in;

  ////////////////////////////////////////
  // SubWord
  ////////////////////////////////////////

  for (genvar i = 0; i < 4; i++) begin : gen_sbox
    aes_sbox u_aes_sbox (
      .data_i ( sub_in[8*i +: 8]  ),
      .data_o ( sub_out[8*i +: 8] )
    );
  end

  // Rcon goes into the first byte only
  always_comb begin
    irregular_o = sub_out;
    if (use_rcon_i) begin
      irregular_o[7:0] = sub_out[7:0] ^ rcon_i;
    end
  end

endmodule

//--- hdl/aes_rcon_gen.sv
/*
  Round constant register for the key schedule.
  Holds zero after reset until the first clear.
  Inverse order halves Rcon, so the clear value must match the key length.
*/
`include "aes_key_params.svh"

module aes_rcon_gen (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    clear_i,
  input  logic                    advance_i,
  input  aes_key_pkg::ciph_op_e   op_i,
  input  aes_key_pkg::key_len_e   key_len_i,
  input  logic [`AES_ROUND_W-1:0] round_i,
  output logic [`AES_RCON_W-1:0]  rcon_o,
  output logic                    use_rcon_o
);

  import aes_key_pkg::*;

  logic [`AES_RCON_W-1:0] rcon_d, rcon_q;
  logic                   rcon_we;

  // Multiply by x in GF(2^8)
  function automatic logic [7:0] gf_mul2(input logic [7:0] x);
    return {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
  endfunction

  // Divide by x, inverse of gf_mul2
  // An odd value had the reduction applied, 0x8d undoes it and restores bit 7
  function automatic logic [7:0] gf_div2(input logic [7:0] x);
    return {1'b0, x[7:1]} ^ (x[0] ? 8'h8d : 8'h00);
  endfunction

  // AES-256 even rounds only run SubWord and take no Rcon
  assign use_rcon_o = !(key_len_i == AES_256 && !round_i[0]);

  // Next value
  always_comb begin
    if (clear_i) begin
      if (op_i == CIPH_FWD) begin
        rcon_d = `AES_RCON_FWD_INIT;
      end else if (key_len_i == AES_128) begin
        rcon_d = `AES_RCON_INV128_INIT;
      end else begin
        rcon_d = `AES_RCON_INV256_INIT;
      end
    end else begin
      rcon_d = (op_i == CIPH_FWD) ? gf_mul2(rcon_q) : gf_div2(rcon_q);
    end
  end

  // Clear wins over a round that is taken
  assign rcon_we = clear_i | (use_rcon_o & advance_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rcon_q <= '0;
    end else if (rcon_we) begin
      rcon_q <= rcon_d;
    end
  end

  assign rcon_o = rcon_q;

endmodule

//--- hdl/aes_sbox.sv
/*
  Forward AES S-Box, one byte, combinational.
  Inverse computed as x^254, so zero maps to zero as the standard requires.
  Deep logic, no attempt at a compact composite-field form.
*/
module aes_sbox (
  input  logic [7:0] data_i,
  output logic [7:0] data_o
);

  logic [7:0] x2, x3, x12, x14, x15, x240, inv;

  // Multiply in GF(2^8) modulo x^8 + x^4 + x^3 + x + 1
  function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] acc;
    logic [7:0] sh;
    acc = 8'h00;
    sh  = a;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) begin
        acc = acc ^ sh;
      end
      // Next power of x times a
      sh = {sh[6:0], 1'b0} ^ (sh[7] ? 8'h1b : 8'h00);
    end
    return acc;
  endfunction

  ////////////////////////////////////////
  // Inversion by square and multiply
  ////////////////////////////////////////

  assign x2   = gf_mul(data_i, data_i);
  assign x3   = gf_mul(x2, data_i);
  // Two squarings take x^3 to x^12
  assign x12  = gf_mul(gf_mul(x3, x3), gf_mul(x3, x3));
  assign x14  = gf_mul(x12, x2);
  assign x15  = gf_mul(x12, x3);
  // Four squarings take x^15 to x^240
  always_comb begin
    x240 = x15;
    for (int i = 0; i < 4; i++) begin
      x240 = gf_mul(x240, x240);
    end
  end
  assign inv  = gf_mul(x240, x14);

  ////////////////////////////////////////
  // Affine transform
  ////////////////////////////////////////

  // Each output bit adds the input bit and the four bits above it, cyclically
  assign data_o = inv ^
                  {inv[6:0], inv[7]}   ^
                  {inv[5:0], inv[7:6]} ^
                  {inv[4:0], inv[7:5]} ^
                  {inv[3:0], inv[7:4]} ^
                  8'h63;

endmodule

//--- hdl/aes_key_pkg.sv
/*
  Types shared by the key expansion modules.
  Byte 0 of a word is its first byte in FIPS-197 order and sits in bits 7:0.
  Word 0 of the key window is the least significant word.
*/
`include "aes_key_params.svh"

package aes_key_pkg;

  // Direction of the key schedule
  typedef enum logic {
    CIPH_FWD = 1'b0,
    CIPH_INV = 1'b1
  } ciph_op_e;

  // Supported key lengths
  typedef enum logic {
    AES_128 = 1'b0,
    AES_256 = 1'b1
  } key_len_e;

  // One 32-bit key word
  typedef logic [`AES_WORD_W-1:0] key_word_t;

  // Full window of eight words
  // AES-128 only uses words 3:0
  typedef key_word_t [`AES_KEY_WORDS-1:0] key_win_t;

endpackage

//--- hdl/aes_key_params.svh
/*
  Fixed dimensions of the AES key expansion datapath.
  Only AES-128 and AES-256 are supported, so the key window is always eight words.
*/
`ifndef AES_KEY_PARAMS_SVH
`define AES_KEY_PARAMS_SVH

// Words held in the key window
`define AES_KEY_WORDS 8
// Bits per key word
`define AES_WORD_W 32
// Round counter width, covers rounds 0 to 14
`define AES_ROUND_W 4
// Round constant width
`define AES_RCON_W 8

// Rcon start values after a clear
`define AES_RCON_FWD_INIT 8'h01
`define AES_RCON_INV128_INIT 8'h36
`define AES_RCON_INV256_INIT 8'h40

`endif
